// File: Makefile
VERILATOR ?= verilator
TOP       ?= csaStreamTb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

SOURCES := $(shell cat files.f)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f files.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: csaDescrambler.sv
`timescale 1ns/1ps
`default_nettype none

module csaDescrambler (
        input  logic       clk,
        input  logic       rst,
        input  logic       payloadValid,
        input  logic [7:0] payload,
        input  logic [7:0] head,
        input  logic       empty,
        output logic       pop,
        output logic       outValid,
        output logic [7:0] outData,
        output logic       underrun
);

        assign pop = payloadValid & ~empty;     // take a key byte per payload byte.

        always_ff @(posedge clk) begin
                if (rst) begin
                        outValid <= 1'b0;
                        underrun <= 1'b0;
                end else begin
                        outValid <= pop;
                        underrun <= payloadValid & empty;  // no key byte ready.
                end
        end

        always_ff @(posedge clk) begin
                if (pop)
                        outData <= payload ^ head;
        end

endmodule

`default_nettype wire

// File: csaKeyFifo.sv
`timescale 1ns/1ps
`default_nettype none

module csaKeyFifo import csaPkg::*; (
        input  logic        clk,
        input  logic        rst,
        input  logic        flush,
        input  csaKeyByte_t keyByte,
        input  logic        pop,
        output logic [7:0]  head,
        output logic        empty
);

        logic [7:0]             mem [csaFifoDepth];
        logic [csaFifoBits-1:0] wrPtr;
        logic [csaFifoBits-1:0] rdPtr;
        logic [csaFifoBits:0]   count;
        logic                   push;
        logic                   doPop;

        assign push  = keyByte.valid & ~flush;  // flush beats a push.
        assign doPop = pop & ~empty;
        assign empty = (count == '0);
        assign head  = mem[rdPtr];

        always_ff @(posedge clk) begin
                if (rst || flush) begin
                        wrPtr <= '0;
                        rdPtr <= '0;
                        count <= '0;
                end else begin
                        if (push)
                                wrPtr <= wrPtr + 1'b1;
                        if (doPop)
                                rdPtr <= rdPtr + 1'b1;
                        // one in and one out leaves the count alone.
                        count <= count + (csaFifoBits + 1)'(push) - (csaFifoBits + 1)'(doPop);
                end
        end

        always_ff @(posedge clk) begin
                if (push)
                        mem[wrPtr] <= keyByte.data;
        end

endmodule

`default_nettype wire

// File: csaPkg.sv
`default_nettype none

package csaPkg;

        localparam int csaNibbles       = 10;   // nibbles per shift register.
        localparam int csaInitRounds    = 32;
        localparam int csaGenRounds     = 32;
        localparam int csaRoundsPerByte = 4;    // 2 keystream bits per round.
        localparam int csaBlockBytes    = 8;
        localparam int csaFifoDepth     = 8;

        localparam int csaTotalRounds   = csaInitRounds + csaGenRounds;
        localparam int csaRoundBits     = $clog2(csaTotalRounds);
        localparam int csaFifoBits      = $clog2(csaFifoDepth);

        // s-box tables, row i holds sbox i+1, indexed by the 5-bit select.
        localparam logic [1:0] csaSbox [7][32] = '{
                '{2, 0, 1, 1, 2, 3, 3, 0, 3, 2, 2, 0, 1, 1, 0, 3,
                  0, 3, 3, 0, 2, 2, 1, 1, 2, 2, 0, 3, 1, 1, 3, 0},
                '{3, 1, 0, 2, 2, 3, 3, 0, 1, 3, 2, 1, 0, 0, 1, 2,
                  3, 1, 0, 3, 3, 2, 0, 2, 0, 0, 1, 2, 2, 1, 3, 1},
                '{2, 0, 1, 2, 2, 3, 3, 1, 1, 1, 0, 3, 3, 0, 2, 0,
                  1, 3, 0, 1, 3, 0, 2, 2, 2, 0, 1, 2, 0, 3, 3, 1},
                '{3, 1, 2, 3, 0, 2, 1, 2, 1, 2, 0, 1, 3, 0, 0, 3,
                  1, 0, 3, 1, 2, 3, 0, 3, 0, 3, 2, 0, 1, 2, 2, 1},
                '{2, 0, 0, 1, 3, 2, 3, 2, 0, 1, 3, 3, 1, 0, 2, 1,
                  2, 3, 2, 0, 0, 3, 1, 1, 1, 0, 3, 2, 3, 1, 0, 2},
                '{0, 1, 2, 3, 1, 2, 2, 0, 0, 1, 3, 0, 2, 3, 1, 3,
                  2, 3, 0, 2, 3, 0, 1, 1, 2, 1, 1, 2, 0, 3, 3, 0},
                '{0, 3, 2, 2, 3, 0, 0, 1, 3, 0, 1, 3, 1, 2, 2, 1,
                  1, 0, 3, 3, 0, 1, 1, 2, 2, 3, 1, 0, 2, 3, 0, 2}
        };

        // one 64-bit cipher word, seen as bytes or as nibbles.
        typedef union packed {
                logic [csaBlockBytes-1:0][7:0]   bytes;     // stream block bytes.
                logic [2*csaBlockBytes-1:0][3:0] nibbles;   // control word nibbles.
        } csaWord_u;

        // complete stream cipher state.
        // regA[k-1] is nibble A(k) of the cipher, same for regB.
        typedef struct packed {
                logic [csaNibbles-1:0][3:0] regA;
                logic [csaNibbles-1:0][3:0] regB;
                logic [3:0]                 x;
                logic [3:0]                 y;
                logic [3:0]                 z;
                logic [3:0]                 d;
                logic [3:0]                 e;
                logic [3:0]                 f;
                logic                       p;  // rotate select for B feedback.
                logic                       q;  // adder enable.
                logic                       r;  // adder carry.
        } csaState_t;

        // keystream byte handed to the buffer.
        typedef struct packed {
                logic [7:0] data;
                logic       valid;
        } csaKeyByte_t;

endpackage

`default_nettype wire

// File: csaRound.sv
`timescale 1ns/1ps
`default_nettype none

module csaRound import csaPkg::*; (
        input  csaState_t  in,
        input  logic [7:0] sbNibbles,   // [7:4] feeds A, [3:0] feeds B.
        input  logic       init,
        output csaState_t  out,
        output logic [1:0] ksBits
);

        logic [6:0][4:0] sIdx;
        logic [6:0][1:0] sOut;
        logic [3:0]      extraB;
        logic [3:0]      feedA;
        logic [3:0]      feedB;
        logic [4:0]      carrySum;

        // 35 bits of A select the seven s-box inputs.
        assign sIdx[0] = {in.regA[3][0], in.regA[0][2], in.regA[5][1],
                          in.regA[6][3], in.regA[8][0]};
        assign sIdx[1] = {in.regA[1][1], in.regA[2][2], in.regA[5][3],
                          in.regA[6][0], in.regA[8][1]};
        assign sIdx[2] = {in.regA[0][3], in.regA[1][0], in.regA[4][1],
                          in.regA[4][3], in.regA[5][2]};
        assign sIdx[3] = {in.regA[2][3], in.regA[0][1], in.regA[1][3],
                          in.regA[3][2], in.regA[7][0]};
        assign sIdx[4] = {in.regA[4][2], in.regA[3][3], in.regA[5][0],
                          in.regA[7][1], in.regA[8][2]};
        assign sIdx[5] = {in.regA[2][1], in.regA[3][1], in.regA[4][0],
                          in.regA[6][2], in.regA[8][3]};
        assign sIdx[6] = {in.regA[1][2], in.regA[2][0], in.regA[6][1],
                          in.regA[7][2], in.regA[7][3]};

        for (genvar i = 0; i < 7; i++) begin : gSbox
                assign sOut[i] = csaSbox[i][sIdx[i]];
        end

        // 4x4 xor network over B, goes into the new D.
        assign extraB[3] = in.regB[2][0] ^ in.regB[5][1] ^ in.regB[6][2] ^ in.regB[8][3];
        assign extraB[2] = in.regB[5][0] ^ in.regB[7][1] ^ in.regB[2][3] ^ in.regB[3][2];
        assign extraB[1] = in.regB[4][3] ^ in.regB[7][2] ^ in.regB[3][0] ^ in.regB[4][1];
        assign extraB[0] = in.regB[8][2] ^ in.regB[5][3] ^ in.regB[2][1] ^ in.regB[7][0];

        assign carrySum = {1'b0, in.z} + {1'b0, in.e} + {4'b0000, in.r};

        always_comb begin
                feedA = in.regA[csaNibbles-1] ^ in.x;
                feedB = in.regB[6] ^ in.regB[csaNibbles-1] ^ in.y;
                if (init) begin
                        feedA = feedA ^ in.d ^ sbNibbles[7:4];  // D only folds in here.
                        feedB = feedB ^ sbNibbles[3:0];
                end
                if (in.p)
                        feedB = {feedB[2:0], feedB[3]};         // rotate left by one.

                out.regA = {in.regA[csaNibbles-2:0], feedA};
                out.regB = {in.regB[csaNibbles-2:0], feedB};

                out.d = in.e ^ in.z ^ extraB;
                out.e = in.f;
                if (in.q) begin
                        out.f = carrySum[3:0];
                        out.r = carrySum[4];
                end else begin
                        out.f = in.e;
                        out.r = in.r;
                end

                // s-box outputs regrouped into the next X, Y, Z, p, q.
                out.x = {sOut[3][0], sOut[2][0], sOut[1][1], sOut[0][1]};
                out.y = {sOut[5][0], sOut[4][0], sOut[3][1], sOut[2][1]};
                out.z = {sOut[1][0], sOut[0][0], sOut[6][1], sOut[5][1]};
                out.p = sOut[4][1];
                out.q = sOut[6][0];
        end

        // two output bits, D folded pairwise.
        assign ksBits = {out.d[3] ^ out.d[2], out.d[1] ^ out.d[0]};

endmodule

`default_nettype wire

// File: csaStreamCore.sv
`timescale 1ns/1ps
`default_nettype none

module csaStreamCore import csaPkg::*; (
        input  logic        clk,
        input  logic        rst,
        input  logic        start,
        input  csaWord_u    ck,
        input  csaWord_u    sb,
        output logic        busy,
        output logic        flush,
        output csaKeyByte_t keyByte
);

        csaState_t               state;
        csaState_t               stateNext;
        csaState_t               stateInit;
        csaWord_u                sbHold;
        logic [csaRoundBits-1:0] roundCnt;      // rounds done in this run.
        logic [2:0]              sbSel;
        logic [7:0]              sbByte;
        logic [7:0]              sbNibbles;
        logic                    initPhase;
        logic                    byteDone;
        logic                    accept;
        logic [1:0]              ksBits;
        logic [5:0]              ksAcc;
        logic [7:0]              keyData;
        logic                    keyValid;

        assign accept = start & ~busy;
        assign flush  = accept;         // drop leftovers of the last run.

        // A and B from ck with the nibbles of each byte swapped, top two nibbles zero.
        always_comb begin
                stateInit = '0;
                for (int i = 0; i < 8; i += 2) begin
                        stateInit.regA[i]     = ck.nibbles[i + 1];
                        stateInit.regA[i + 1] = ck.nibbles[i];
                        stateInit.regB[i]     = ck.nibbles[i + 9];
                        stateInit.regB[i + 1] = ck.nibbles[i + 8];
                end
        end

        assign initPhase = roundCnt < csaRoundBits'(csaInitRounds);
        assign sbSel     = 3'(roundCnt / csaRoundsPerByte);
        assign sbByte    = sbHold.bytes[sbSel];
        // odd rounds swap which half goes to A and which to B.
        assign sbNibbles = roundCnt[0] ? {sbByte[3:0], sbByte[7:4]} : sbByte;

        assign byteDone = busy && !initPhase &&
                          (roundCnt % csaRoundsPerByte == csaRoundsPerByte - 1);

        csaRound i_round (
                .in        (state),
                .sbNibbles (sbNibbles),
                .init      (initPhase),
                .out       (stateNext),
                .ksBits    (ksBits)
        );

        always_ff @(posedge clk) begin
                if (rst) begin
                        busy     <= 1'b0;
                        roundCnt <= '0;
                        keyValid <= 1'b0;
                end else begin
                        keyValid <= byteDone;
                        if (accept) begin
                                busy     <= 1'b1;
                                roundCnt <= '0;
                        end else if (busy) begin
                                roundCnt <= roundCnt + 1'b1;
                                if (roundCnt == csaRoundBits'(csaTotalRounds - 1))
                                        busy <= 1'b0;   // last generation round.
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (accept) begin
                        state  <= stateInit;
                        sbHold <= sb;
                end else if (busy) begin
                        state <= stateNext;
                end
                if (busy)
                        ksAcc <= {ksAcc[3:0], ksBits};
                if (byteDone)
                        keyData <= {ksAcc, ksBits};     // first pair lands in the msbs.
        end

        assign keyByte = '{data: keyData, valid: keyValid};

endmodule

`default_nettype wire

// File: csaStreamTb.sv
`timescale 1ns/1ps
`default_nettype none

module csaStreamTb import csaPkg::*; ();

        localparam int numVectors = 4;
        localparam int cycleLimit = numVectors * 100 + 500;

        logic        clk = 1'b0;
        logic        rst;
        logic        start;
        csaWord_u    ck;
        csaWord_u    sb;
        logic        payloadValid;
        logic [7:0]  payload;
        logic        busy;
        logic        outValid;
        logic [7:0]  outData;
        logic        underrun;

        logic [63:0] traceMem [2*numVectors];   // ck then sb per vector.
        logic [7:0]  expKey [csaBlockBytes];
        logic [31:0] lfsr;
        int          byteErrors;
        int          flagErrors;
        int          countErrors;
        int          cycles;

        always #2 clk = ~clk;

        csaStreamTop i_dut (
                .clk          (clk),
                .rst          (rst),
                .start        (start),
                .ck           (ck),
                .sb           (sb),
                .payloadValid (payloadValid),
                .payload      (payload),
                .busy         (busy),
                .outValid     (outValid),
                .outData      (outData),
                .underrun     (underrun)
        );

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= cycleLimit) begin
                        $display("timeout after %0d cycles, the run did not finish", cycles);
                        $display("Errors found");
                        $finish;
                end
        end

        // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1.
        function automatic logic [31:0] lfsrStep(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        endfunction

        function automatic logic [7:0] nextPayload();
                logic [7:0] b;
                b = '0;
                for (int i = 0; i < 8; i++) begin
                        lfsr = lfsrStep(lfsr);
                        b    = {b[6:0], lfsr[0]};
                end
                return b;
        endfunction

        // cipher model over 32 init rounds and 32 rounds of two output bits.
        task automatic computeKeystream(input int v);
                logic [63:0]     ckW;
                logic [63:0]     sbW;
                logic [3:0]      ra [10];
                logic [3:0]      rb [10];
                logic [3:0]      x;
                logic [3:0]      y;
                logic [3:0]      z;
                logic [3:0]      d;
                logic [3:0]      e;
                logic [3:0]      f;
                logic [3:0]      nextE;
                logic            p;
                logic            q;
                logic            r;
                logic [1:0]      so [7];
                logic [4:0]      idx [7];
                logic [3:0]      eb;
                logic [3:0]      fa;
                logic [3:0]      fb;
                logic [3:0]      inA;
                logic [3:0]      inB;
                logic [4:0]      sum;
                logic [7:0]      sbB;
                logic [7:0]      acc;
                logic [1:0]      ks;
                ckW = traceMem[2*v];
                sbW = traceMem[2*v+1];
                x   = '0;
                y   = '0;
                z   = '0;
                d   = '0;
                e   = '0;
                f   = '0;
                p   = 1'b0;
                q   = 1'b0;
                r   = 1'b0;
                acc = '0;
                for (int k = 0; k < 10; k++) begin
                        ra[k] = '0;
                        rb[k] = '0;
                end
                for (int i = 0; i < 8; i += 2) begin    // nibble pairs swapped.
                        ra[i]   = ckW[4*(i+1) +: 4];
                        ra[i+1] = ckW[4*i +: 4];
                        rb[i]   = ckW[4*(i+9) +: 4];
                        rb[i+1] = ckW[4*(i+8) +: 4];
                end
                for (int n = 0; n < 64; n++) begin
                        sbB = sbW[8*((n/4)%8) +: 8];
                        inA = (n % 2 == 1) ? sbB[3:0] : sbB[7:4];
                        inB = (n % 2 == 1) ? sbB[7:4] : sbB[3:0];
                        idx[0] = {ra[3][0], ra[0][2], ra[5][1], ra[6][3], ra[8][0]};
                        idx[1] = {ra[1][1], ra[2][2], ra[5][3], ra[6][0], ra[8][1]};
                        idx[2] = {ra[0][3], ra[1][0], ra[4][1], ra[4][3], ra[5][2]};
                        idx[3] = {ra[2][3], ra[0][1], ra[1][3], ra[3][2], ra[7][0]};
                        idx[4] = {ra[4][2], ra[3][3], ra[5][0], ra[7][1], ra[8][2]};
                        idx[5] = {ra[2][1], ra[3][1], ra[4][0], ra[6][2], ra[8][3]};
                        idx[6] = {ra[1][2], ra[2][0], ra[6][1], ra[7][2], ra[7][3]};
                        for (int i = 0; i < 7; i++)
                                so[i] = csaSbox[i][idx[i]];
                        eb[3] = rb[2][0] ^ rb[5][1] ^ rb[6][2] ^ rb[8][3];
                        eb[2] = rb[5][0] ^ rb[7][1] ^ rb[2][3] ^ rb[3][2];
                        eb[1] = rb[4][3] ^ rb[7][2] ^ rb[3][0] ^ rb[4][1];
                        eb[0] = rb[8][2] ^ rb[5][3] ^ rb[2][1] ^ rb[7][0];
                        sum = {1'b0, z} + {1'b0, e} + {4'b0000, r};
                        fa = ra[9] ^ x;
                        fb = rb[6] ^ rb[9] ^ y;
                        if (n < csaInitRounds) begin
                                fa = fa ^ d ^ inA;
                                fb = fb ^ inB;
                        end
                        if (p)
                                fb = {fb[2:0], fb[3]};
                        for (int k = 9; k > 0; k--) begin
                                ra[k] = ra[k-1];
                                rb[k] = rb[k-1];
                        end
                        ra[0] = fa;
                        rb[0] = fb;
                        d = e ^ z ^ eb;
                        nextE = f;
                        if (q) begin
                                f = sum[3:0];
                                r = sum[4];
                        end else begin
                                f = e;                  // old e moves into f.
                        end
                        e = nextE;
                        x = {so[3][0], so[2][0], so[1][1], so[0][1]};
                        y = {so[5][0], so[4][0], so[3][1], so[2][1]};
                        z = {so[1][0], so[0][0], so[6][1], so[5][1]};
                        p = so[4][1];
                        q = so[6][0];
                        ks = {d[3] ^ d[2], d[1] ^ d[0]};
                        if (n >= csaInitRounds) begin
                                acc = {acc[5:0], ks};
                                if ((n - csaInitRounds) % csaRoundsPerByte == 3)
                                        expKey[(n - csaInitRounds) / csaRoundsPerByte] = acc;
                        end
                end
        endtask

        task automatic checkByte(input logic [7:0] got, input logic [7:0] exp, input string msg);
                if (got !== exp) begin
                        $display("FAIL %0t %s: got %02h, expected %02h", $time, msg, got, exp);
                        byteErrors++;
                end
        endtask

        task automatic checkFlag(input logic got, input logic exp, input string msg);
                if (got !== exp) begin
                        $display("FAIL %0t %s: got %b, expected %b", $time, msg, got, exp);
                        flagErrors++;
                end
        endtask

        task automatic checkCount(input int got, input int exp, input string msg);
                if (got != exp) begin
                        $display("FAIL %0t %s: got %0d, expected %0d", $time, msg, got, exp);
                        countErrors++;
                end
        endtask

        task automatic launch(input int v);
                @(negedge clk);
                start = 1'b1;
                ck    = traceMem[2*v];
                sb    = traceMem[2*v+1];
                @(negedge clk);
                start = 1'b0;
                checkFlag(busy, 1'b1, "busy one cycle after start");
        endtask

        // counts busy cycles and can fire a start with vector vOther at cycle ignoreAt.
        task automatic waitIdle(input int ignoreAt, input int vOther);
                int n;
                n = 0;
                while (busy) begin
                        n++;
                        start = (n == ignoreAt);
                        if (n == ignoreAt) begin
                                ck = traceMem[2*vOther];
                                sb = traceMem[2*vOther+1];
                        end
                        @(negedge clk);
                end
                start = 1'b0;
                checkCount(n, csaTotalRounds, "busy length");
        endtask

        task automatic sendByte(input int k);
                logic [7:0] pl;
                pl           = nextPayload();
                payloadValid = 1'b1;
                payload      = pl;
                @(negedge clk);
                payloadValid = 1'b0;
                checkFlag(outValid, 1'b1, "outValid for payload");
                checkFlag(underrun, 1'b0, "no underrun with key bytes ready");
                checkByte(outData, pl ^ expKey[k], $sformatf("descrambled byte %0d", k));
        endtask

        task automatic sendEmpty(input string msg);
                payloadValid = 1'b1;
                payload      = nextPayload();
                @(negedge clk);
                payloadValid = 1'b0;
                checkFlag(underrun, 1'b1, msg);
                checkFlag(outValid, 1'b0, msg);
        endtask

        initial begin
                rst          = 1'b1;
                start        = 1'b0;
                ck           = '0;
                sb           = '0;
                payloadValid = 1'b0;
                payload      = '0;
                lfsr         = 32'hd365_7881;
                byteErrors   = 0;
                flagErrors   = 0;
                countErrors  = 0;
                cycles       = 0;
                $readmemh("csaStreamTrace.txt", traceMem);
                repeat (10) @(negedge clk);
                rst = 1'b0;
                checkFlag(busy, 1'b0, "busy after reset");
                sendEmpty("underrun before any start");

                for (int v = 0; v < numVectors; v++) begin
                        computeKeystream(v);
                        launch(v);
                        waitIdle(-1, 0);
                        for (int k = 0; k < csaBlockBytes; k++)
                                sendByte(k);
                        sendEmpty("underrun after all bytes used");
                end

                // a second start while busy must be ignored.
                computeKeystream(0);
                launch(0);
                waitIdle(5, 1);
                for (int k = 0; k < csaBlockBytes; k++)
                        sendByte(k);

                // restart after partial use drops the leftovers.
                computeKeystream(1);
                launch(1);
                waitIdle(-1, 0);
                for (int k = 0; k < 3; k++)
                        sendByte(k);
                computeKeystream(2);
                launch(2);
                waitIdle(-1, 0);
                for (int k = 0; k < csaBlockBytes; k++)
                        sendByte(k);
                sendEmpty("underrun after restart block used");

                // reset in the middle of a run once a few key bytes are buffered.
                launch(3);
                repeat (50) @(negedge clk);
                rst = 1'b1;
                repeat (3) @(negedge clk);
                rst = 1'b0;
                checkFlag(busy, 1'b0, "busy cleared by reset");
                sendEmpty("underrun after reset during run");

                $display("byte errors %0d, flag errors %0d, count errors %0d",
                         byteErrors, flagErrors, countErrors);
                if (byteErrors + flagErrors + countErrors == 0)
                        $display("No errors");
                else
                        $display("Errors found");
                $finish;
        end

endmodule

`default_nettype wire

// File: csaStreamTop.sv
`timescale 1ns/1ps
`default_nettype none

module csaStreamTop import csaPkg::*; (
        input  logic       clk,
        input  logic       rst,
        input  logic       start,
        input  csaWord_u   ck,
        input  csaWord_u   sb,
        input  logic       payloadValid,
        input  logic [7:0] payload,
        output logic       busy,
        output logic       outValid,
        output logic [7:0] outData,
        output logic       underrun
);

        csaKeyByte_t keyByte;
        logic        flush;
        logic [7:0]  head;
        logic        empty;
        logic        pop;

        // keystream producer.
        csaStreamCore i_core (
                .clk     (clk),
                .rst     (rst),
                .start   (start),
                .ck      (ck),
                .sb      (sb),
                .busy    (busy),
                .flush   (flush),
                .keyByte (keyByte)
        );

        csaKeyFifo i_fifo (
                .clk     (clk),
                .rst     (rst),
                .flush   (flush),
                .keyByte (keyByte),
                .pop     (pop),
                .head    (head),
                .empty   (empty)
        );

        // payload side.
        csaDescrambler i_descr (
                .clk          (clk),
                .rst          (rst),
                .payloadValid (payloadValid),
                .payload      (payload),
                .head         (head),
                .empty        (empty),
                .pop          (pop),
                .outValid     (outValid),
                .outData      (outData),
                .underrun     (underrun)
        );

endmodule

`default_nettype wire

// File: csaStreamTrace.txt
// columns: ck (64-bit control word) then sb (64-bit stream block)
// one vector per line, hex
0123456789abcdef fedcba9876543210
1122334455667788 8877665544332211
a5c3e1f00f1e3c5a 5f3c9d0172e84b6a
deadbeef00c0ffee 0f0e0d0c0b0a0908

// File: csaStream_assert.sv
`timescale 1ns/1ps
`default_nettype none

module csaStreamAssert import csaPkg::*; (
        input wire logic                    clk,
        input wire logic                    rst,
        input wire logic                    busy,
        input wire logic                    start,
        input wire logic [csaRoundBits-1:0] roundCnt,
        input wire logic                    outValid,
        input wire logic                    underrun
);

        int busyLen;    // edges seen with busy high.

        always_ff @(posedge clk) begin
                if (rst || !busy)
                        busyLen <= 0;
                else
                        busyLen <= busyLen + 1;
        end

        assert property (@(posedge clk) disable iff (rst) !(outValid && underrun))
                else $error("outValid and underrun high together");

        assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> busyLen == 64)
                else $error("busy did not last 64 cycles");

        // an ignored start lets the round counter run on.
        assert property (@(posedge clk) disable iff (rst)
                busy && start |=> roundCnt == $past(roundCnt) + 1'b1)
                else $error("start accepted while busy");

endmodule

bind csaStreamTop csaStreamAssert i_assert (
        .clk      (clk),
        .rst      (rst),
        .busy     (busy),
        .start    (start),
        .roundCnt (i_core.roundCnt),
        .outValid (outValid),
        .underrun (underrun)
);

`default_nettype wire

// File: files.f
csaPkg.sv
csaRound.sv
csaKeyFifo.sv
csaDescrambler.sv
csaStreamCore.sv
csaStreamTop.sv
csaStream_assert.sv
csaStreamTb.sv
